/* build.f */
+incdir+.
vgen_pkg.sv
vgen_reg_decode.sv
vgen_sync_timing.sv
vgen_line_fetch.sv
vgen_pixel_out.sv
vgen_top.sv
vgen_chk.sv
vgen_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the video generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -f build.f --top-module vgen_tb -o vgen_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vgen_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* vgen_tb.sv */
// video generator testbench
`timescale 1ns/1ps
`include "vgen_params.svh"

module vgen_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int H_TOTAL      = `VGEN_H_FRONT + `VGEN_H_SYNC + `VGEN_H_BACK + `VGEN_H_VISIBLE;
    localparam int V_TOTAL      = `VGEN_V_VISIBLE + `VGEN_V_FRONT + `VGEN_V_SYNC + `VGEN_V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;
    localparam logic [31:0] SEED = 32'hc06d_3de4;

    logic                       clk = 1'b0;
    logic                       reset_i;
    logic [2:0]                 paddr_i;
    logic                       psel_i;
    logic                       penable_i;
    logic                       pwrite_i;
    logic [15:0]                pwdata_i;
    logic [15:0]                prdata_o;
    logic                       pready_o;
    logic                       pslverr_o;
    logic                       vram_sel_o;
    logic [`VGEN_ADDR_W-1:0]    vram_addr_o;
    logic [15:0]                vram_data_i = 16'h0000;
    logic [7:0]                 color_index_o;
    logic                       hsync_o;
    logic                       vsync_o;
    logic                       dv_de_o;

    logic                       rd_pend = 1'b0;     // read issued in the previous cycle
    logic [`VGEN_ADDR_W-1:0]    rd_pend_addr;
    int                         n_checks;
    int                         n_errors;
    int                         n_asserts;

    vgen_top i_dut (
        .clk, .reset_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o, .vram_sel_o, .vram_addr_o, .vram_data_i,
        .color_index_o, .hsync_o, .vsync_o, .dv_de_o
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // vram content is a pure function of the word address
    function automatic logic [15:0] vram_word(input logic [15:0] addr);
        logic [31:0] r;
        r = xorshift32(SEED ^ {16'h0000, addr});
        return r[15:0];
    endfunction

    // vram answers one cycle after each select
    always @(negedge clk) begin
        if (rd_pend) begin
            vram_data_i <= vram_word(rd_pend_addr);
        end
        rd_pend      <= vram_sel_o;
        rd_pend_addr <= vram_addr_o;
    end

    function automatic logic [7:0] expected_pixel(input logic bpp4, input logic [7:0] cb,
            input logic [15:0] disp, input logic [15:0] ll, input int x, input int y);
        logic [15:0] addr;
        logic [15:0] w;
        logic [3:0]  idx;
        if (bpp4) begin
            addr = disp + 16'(y) * ll + 16'(x / 4);
            w    = vram_word(addr);
            idx  = 4'(4 * (3 - x % 4));         // leftmost pixel in the top nibble
            return {cb[7:4], w[idx +: 4]};
        end
        addr = disp + 16'(y) * ll + 16'(x / 8);
        w    = vram_word(addr);
        idx  = 4'(7 - x % 8);
        return {cb[7:4], w[idx] ? w[15:12] : w[11:8]};
    endfunction

    task automatic check_equal(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        n_checks++;
        assert (got === expected) else begin
            n_errors++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        n_errors++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    task automatic apb_transfer(input logic write, input logic [2:0] addr,
                                input logic [15:0] wdata, output logic [15:0] rdata,
                                output logic err);
        int   cycles;
        logic done;
        paddr_i   = addr;
        pwrite_i  = write;
        pwdata_i  = wdata;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(negedge clk);
        penable_i = 1'b1;
        cycles    = 0;
        done      = 1'b0;
        rdata     = 16'h0000;
        err       = 1'b0;
        while (!done && cycles < WAIT_LIMIT) begin
            #(CLK_PERIOD / 4);                  // mid access phase
            if (pready_o) begin
                rdata = prdata_o;
                err   = pslverr_o;
                done  = 1'b1;
            end
            @(negedge clk);
            cycles++;
        end
        assert (done) else report_failure("APB slave never raised pready_o");
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input logic [2:0] addr, input logic [15:0] data,
                             input logic exp_err);
        logic [15:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        check_equal($sformatf("pslverr_o (write %0d)", addr), 16'(err), 16'(exp_err));
    endtask

    task automatic apb_read(input logic [2:0] addr, input logic exp_err,
                            output logic [15:0] rdata);
        logic err;
        apb_transfer(1'b0, addr, 16'h0000, rdata, err);
        check_equal($sformatf("pslverr_o (read %0d)", addr), 16'(err), 16'(exp_err));
    endtask

    // returns on the first cycle with vsync_o active
    task automatic wait_vsync_rise();
        int cycles;
        cycles = 0;
        while (vsync_o == `VGEN_SYNC_POL && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < WAIT_LIMIT) else report_failure("vsync_o stuck active");
        cycles = 0;
        while (vsync_o != `VGEN_SYNC_POL && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < WAIT_LIMIT) else report_failure("no vsync_o pulse");
    endtask

    task automatic wait_de();
        int cycles;
        cycles = 0;
        while (!dv_de_o && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < WAIT_LIMIT) else report_failure("no dv_de_o on a visible line");
    endtask

    task automatic check_frame(input logic bpp4, input logic [7:0] cb,
                               input logic [15:0] disp, input logic [15:0] ll);
        logic [7:0] expected;
        wait_vsync_rise();                      // let a frame settle on the new config
        wait_vsync_rise();
        for (int y = 0; y < `VGEN_V_VISIBLE; y++) begin
            wait_de();
            for (int x = 0; x < `VGEN_H_VISIBLE; x++) begin
                expected = expected_pixel(bpp4, cb, disp, ll, x, y);
                check_equal("dv_de_o", 16'(dv_de_o), 16'h0001);
                check_equal($sformatf("color_index_o (x %0d, y %0d)", x, y),
                            16'(color_index_o), 16'(expected));
                @(negedge clk);
            end
        end
    endtask

    task automatic test_registers();
        logic [15:0] rdata;
        apb_read(`VGEN_REG_VID_CTRL, 1'b0, rdata);
        check_equal("VID_CTRL", rdata, {`VGEN_RST_BORDER, 8'h00});
        apb_read(`VGEN_REG_GFX_CTRL, 1'b0, rdata);
        check_equal("GFX_CTRL", rdata, 16'h0000);
        apb_read(`VGEN_REG_DISP_ADDR, 1'b0, rdata);
        check_equal("DISP_ADDR", rdata, 16'h0000);
        apb_read(`VGEN_REG_LINE_LEN, 1'b0, rdata);
        check_equal("LINE_LEN", rdata, `VGEN_RST_LINE_LEN);
        apb_read(`VGEN_REG_SCANLINE, 1'b0, rdata);
        check_equal("SCANLINE[13:11]", 16'(rdata[13:11]), 16'h0000);
        apb_write(`VGEN_REG_VID_CTRL, 16'h5aff, 1'b0);
        apb_write(`VGEN_REG_GFX_CTRL, 16'hc3ff, 1'b0);
        apb_write(`VGEN_REG_DISP_ADDR, 16'h1234, 1'b0);
        apb_write(`VGEN_REG_LINE_LEN, 16'h0007, 1'b0);
        apb_read(`VGEN_REG_VID_CTRL, 1'b0, rdata);
        check_equal("VID_CTRL", rdata, 16'h5a00);
        apb_read(`VGEN_REG_GFX_CTRL, 1'b0, rdata);
        check_equal("GFX_CTRL", rdata, 16'hc390);  // colorbase, blank and bpp only
        apb_read(`VGEN_REG_DISP_ADDR, 1'b0, rdata);
        check_equal("DISP_ADDR", rdata, 16'h1234);
        apb_read(`VGEN_REG_LINE_LEN, 1'b0, rdata);
        check_equal("LINE_LEN", rdata, 16'h0007);
        apb_write(3'd5, 16'hffff, 1'b1);
        apb_write(`VGEN_REG_SCANLINE, 16'h0000, 1'b1);
        apb_read(3'd7, 1'b1, rdata);
        apb_write(`VGEN_REG_VID_CTRL, {`VGEN_RST_BORDER, 8'h00}, 1'b0);
        apb_write(`VGEN_REG_GFX_CTRL, 16'h0000, 1'b0);
        apb_write(`VGEN_REG_DISP_ADDR, 16'h0000, 1'b0);
        apb_write(`VGEN_REG_LINE_LEN, `VGEN_RST_LINE_LEN, 1'b0);
    endtask

    task automatic test_frame_timing();
        int   de_bursts, de_run, hs_pulses, hs_run, vs_pulses, vs_cycles;
        logic de_prev, hs_prev, vs_prev, hs_on, vs_on;
        de_bursts = 0;
        de_run    = 0;
        hs_pulses = 0;
        hs_run    = 0;
        vs_pulses = 0;
        vs_cycles = 0;
        de_prev   = 1'b0;
        hs_prev   = 1'b0;
        vs_prev   = 1'b0;
        wait_vsync_rise();
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            hs_on = hsync_o == `VGEN_SYNC_POL;
            vs_on = vsync_o == `VGEN_SYNC_POL;
            if (dv_de_o) begin
                de_run++;
            end else if (de_prev) begin
                check_equal("dv_de_o burst length", 16'(de_run), 16'(`VGEN_H_VISIBLE));
                de_bursts++;
                de_run = 0;
            end
            if (hs_on) begin
                hs_run++;
            end else if (hs_prev) begin
                check_equal("hsync_o pulse length", 16'(hs_run), 16'(`VGEN_H_SYNC));
                hs_pulses++;
                hs_run = 0;
            end
            if (vs_on) begin
                vs_cycles++;
                vs_pulses = vs_prev ? vs_pulses : vs_pulses + 1;
            end
            de_prev = dv_de_o;
            hs_prev = hs_on;
            vs_prev = vs_on;
            @(negedge clk);
        end
        check_equal("dv_de_o bursts", 16'(de_bursts), 16'(`VGEN_V_VISIBLE));
        check_equal("hsync_o pulses", 16'(hs_pulses), 16'(V_TOTAL));
        check_equal("vsync_o pulses", 16'(vs_pulses), 16'h0001);
        check_equal("vsync_o cycles", 16'(vs_cycles), 16'(H_TOTAL * `VGEN_V_SYNC));
    endtask

    task automatic test_attr_mode();
        apb_write(`VGEN_REG_GFX_CTRL, 16'ha500, 1'b0);
        apb_write(`VGEN_REG_DISP_ADDR, 16'h0100, 1'b0);
        apb_write(`VGEN_REG_LINE_LEN, 16'h0004, 1'b0);
        check_frame(1'b0, 8'ha5, 16'h0100, 16'h0004);
    endtask

    task automatic test_nibble_mode();
        apb_write(`VGEN_REG_GFX_CTRL, 16'h7c10, 1'b0);
        apb_write(`VGEN_REG_DISP_ADDR, 16'h2000, 1'b0);
        apb_write(`VGEN_REG_LINE_LEN, 16'h0008, 1'b0);
        check_frame(1'b1, 8'h7c, 16'h2000, 16'h0008);
        apb_write(`VGEN_REG_DISP_ADDR, 16'h3f00, 1'b0);
        apb_write(`VGEN_REG_LINE_LEN, 16'h000b, 1'b0);
        check_frame(1'b1, 8'h7c, 16'h3f00, 16'h000b);
    endtask

    task automatic test_blank_border();
        logic [15:0] rdata;
        int          de_cycles;
        de_cycles = 0;
        apb_write(`VGEN_REG_VID_CTRL, 16'h3c00, 1'b0);
        apb_write(`VGEN_REG_GFX_CTRL, 16'h7c90, 1'b0);
        wait_vsync_rise();
        apb_read(`VGEN_REG_SCANLINE, 1'b0, rdata);
        check_equal("SCANLINE[15]", 16'(rdata[15]), 16'h0001);
        check_equal("SCANLINE[10:0]", 16'(rdata[10:0]), 16'(`VGEN_V_VISIBLE + `VGEN_V_FRONT));
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            check_equal("vram_sel_o", 16'(vram_sel_o), 16'h0000);
            if (dv_de_o) begin
                check_equal("color_index_o", 16'(color_index_o), 16'h003c);
                de_cycles++;
            end
            @(negedge clk);
        end
        check_equal("blanked dv_de_o cycles", 16'(de_cycles),
                    16'(`VGEN_H_VISIBLE * `VGEN_V_VISIBLE));
        apb_write(`VGEN_REG_GFX_CTRL, 16'h0000, 1'b0);
        apb_write(`VGEN_REG_VID_CTRL, {`VGEN_RST_BORDER, 8'h00}, 1'b0);
    endtask

    initial begin
        reset_i   = 1'b1;
        paddr_i   = 3'd0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        pwdata_i  = 16'h0000;
        n_checks  = 0;
        n_errors  = 0;
        repeat (4) @(negedge clk);
        reset_i = 1'b0;
        test_registers();
        test_frame_timing();
        test_attr_mode();
        test_nibble_mode();
        test_blank_border();
        n_asserts = i_dut.i_chk.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, n_asserts);
        if (n_errors == 0 && n_asserts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* vgen_chk.sv */
// video generator protocol checks
`timescale 1ns/1ps
`include "vgen_params.svh"

module vgen_chk (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    psel_i,
    input  logic    penable_i,
    input  logic    pready_i,
    input  logic    dv_de_i,
    input  logic    hsync_i,
    input  logic    vsync_i,
    input  logic    vram_sel_i,
    input  logic    blank_i
);

    int fail_count = 0;             // assertion failures so far

    // zero wait states, so pready marks exactly the access phase
    pready_in_access: assert property (@(posedge clk) disable iff (reset_i)
        pready_i |-> (psel_i && penable_i))
        else begin
            fail_count++;
            $error("pready_o outside the APB access phase");
        end

    de_outside_sync: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_i |-> (hsync_i != `VGEN_SYNC_POL && vsync_i != `VGEN_SYNC_POL))
        else begin
            fail_count++;
            $error("dv_de_o active during a sync pulse");
        end

    no_read_blanked: assert property (@(posedge clk) disable iff (reset_i)
        blank_i |-> !vram_sel_i)
        else begin
            fail_count++;
            $error("vram_sel_o while the plane is blanked");
        end

endmodule

bind vgen_top vgen_chk i_chk (
    .clk, .reset_i, .psel_i, .penable_i,
    .pready_i(pready_o), .dv_de_i(dv_de_o), .hsync_i(hsync_o), .vsync_i(vsync_o),
    .vram_sel_i(vram_sel_o), .blank_i(cfg.blank)
);

/* vgen_top.sv */
// video generator top level
`timescale 1ns/1ps
`include "vgen_params.svh"

module vgen_top (
    input  logic                        clk,
    input  logic                        reset_i,
    // APB slave
    input  logic [2:0]                  paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [15:0]                 pwdata_i,
    output logic [15:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    // vram read port
    output logic                        vram_sel_o,
    output logic [`VGEN_ADDR_W-1:0]     vram_addr_o,
    input  logic [15:0]                 vram_data_i,
    // video out
    output logic [7:0]                  color_index_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

    import vgen_pkg::*;

    pa_cfg_t        cfg;
    timing_t        timing;
    pixel_group_t   grp;
    logic [7:0]     border;
    logic           line_start, scan_active;
    logic           hsync, vsync, de;
    logic           grp_valid, grp_ready;

    vgen_reg_decode i_reg_decode (
        .clk, .reset_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .timing_i(timing), .cfg_o(cfg), .border_o(border)
    );

    vgen_sync_timing i_sync_timing (
        .clk, .reset_i, .timing_o(timing), .line_start_o(line_start),
        .scan_active_o(scan_active), .hsync_o(hsync), .vsync_o(vsync), .de_o(de)
    );

    vgen_line_fetch i_line_fetch (
        .clk, .reset_i, .cfg_i(cfg), .timing_i(timing), .line_start_i(line_start),
        .vram_sel_o, .vram_addr_o, .vram_data_i,
        .grp_o(grp), .grp_valid_o(grp_valid), .grp_ready_i(grp_ready)
    );

    vgen_pixel_out i_pixel_out (
        .clk, .reset_i, .grp_i(grp), .grp_valid_i(grp_valid), .grp_ready_o(grp_ready),
        .scan_active_i(scan_active), .blank_i(cfg.blank), .border_i(border), .color_index_o
    );

    // same register stage as color_index_o
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o <= ~`VGEN_SYNC_POL;
            vsync_o <= ~`VGEN_SYNC_POL;
            dv_de_o <= 1'b0;
        end else begin
            hsync_o <= hsync;
            vsync_o <= vsync;
            dv_de_o <= de;
        end
    end

endmodule

/* vgen_pixel_out.sv */
// pixel shift-out and border select
`timescale 1ns/1ps

module vgen_pixel_out (
    input  logic                    clk,
    input  logic                    reset_i,
    input  vgen_pkg::pixel_group_t  grp_i,
    input  logic                    grp_valid_i,
    output logic                    grp_ready_o,
    input  logic                    scan_active_i,  // next cycle is in the visible area
    input  logic                    blank_i,
    input  logic [7:0]              border_i,
    output logic [7:0]              color_index_o
);

    import vgen_pkg::*;

    pixel_group_t   hold_q;             // next group waiting for shift-out
    pixel_group_t   shift_q;            // current pixel in the top byte
    logic           hold_valid;
    logic           active_q;           // visible area, in step with de
    logic [2:0]     pix_cnt;
    logic           line_load;
    logic           grp_load;

    assign grp_ready_o = !hold_valid;
    assign line_load   = scan_active_i && !active_q;           // cycle before first pixel
    assign grp_load    = line_load || (active_q && pix_cnt == 3'd7);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hold_valid <= 1'b0;
            active_q   <= 1'b0;
            pix_cnt    <= 3'd0;
        end else begin
            active_q <= scan_active_i;
            if (blank_i) begin
                hold_valid <= 1'b0;
            end else if (grp_valid_i && grp_ready_o) begin
                hold_valid <= 1'b1;
            end else if (grp_load) begin
                hold_valid <= 1'b0;
            end
            if (line_load) begin
                pix_cnt <= 3'd0;
            end else if (active_q) begin
                pix_cnt <= pix_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grp_valid_i && grp_ready_o) begin
            hold_q <= grp_i;
        end
        if (grp_load && hold_valid) begin
            shift_q <= hold_q;
        end else if (active_q) begin
            shift_q <= {shift_q[6:0], 8'h00};
        end
        // border outside the scan area or when the plane is blanked
        color_index_o <= (active_q && !blank_i) ? shift_q[7] : border_i;
    end

endmodule

/* vgen_line_fetch.sv */
// bitmap line fetch and pixel expansion
`timescale 1ns/1ps
`include "vgen_params.svh"

module vgen_line_fetch (
    input  logic                            clk,
    input  logic                            reset_i,
    input  vgen_pkg::pa_cfg_t               cfg_i,
    input  vgen_pkg::timing_t               timing_i,
    input  logic                            line_start_i,
    output logic                            vram_sel_o,
    output logic [`VGEN_ADDR_W-1:0]         vram_addr_o,
    input  logic [15:0]                     vram_data_i,    // valid one cycle after select
    output vgen_pkg::pixel_group_t          grp_o,
    output logic                            grp_valid_o,
    input  logic                            grp_ready_i
);

    import vgen_pkg::*;

    localparam int GRP_W = $clog2(`VGEN_H_VISIBLE / 8);
    localparam logic [GRP_W-1:0] GRP_LAST = GRP_W'(`VGEN_H_VISIBLE / 8 - 1);

    logic                       busy;           // line fetch in progress
    logic [1:0]                 phase;          // issue cycle within a group
    logic [GRP_W-1:0]           grp_cnt;
    logic [`VGEN_ADDR_W-1:0]    rd_addr;
    logic [`VGEN_ADDR_W-1:0]    line_addr;      // start of the next line
    vram_word_u                 rd_word;
    vram_word_u                 word_q;         // first word of a 4-bpp group
    pixel_group_t               attr_grp, nib_grp;
    logic                       go, step, last_phase;
    logic [3:0]                 cb;

    assign rd_word    = vram_data_i;
    assign cb         = cfg_i.colorbase[7:4];
    assign last_phase = (cfg_i.bpp == BPP_4) ? (phase == 2'd2) : (phase == 2'd1);
    assign go         = !grp_valid_o || grp_ready_i;     // group slot free for the next result
    assign step       = busy && !cfg_i.blank && (phase != 2'd0 || go);

    // one read per group at 1-bpp, two at 4-bpp
    assign vram_sel_o  = step && (phase == 2'd0 || (phase == 2'd1 && cfg_i.bpp == BPP_4));
    assign vram_addr_o = rd_addr;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            attr_grp[i] = {cb, rd_word.attr_view.pix[i] ? rd_word.attr_view.fg
                                                         : rd_word.attr_view.bg};
        end
        for (int i = 0; i < 4; i++) begin
            nib_grp[i + 4] = {cb, word_q.nib_view.pix[i]};
            nib_grp[i]     = {cb, rd_word.nib_view.pix[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy        <= 1'b0;
            phase       <= 2'd0;
            grp_cnt     <= '0;
            grp_valid_o <= 1'b0;
        end else if (cfg_i.blank) begin
            busy        <= 1'b0;                // drop the line, no reads while blanked
            phase       <= 2'd0;
            grp_valid_o <= 1'b0;
        end else begin
            if (grp_valid_o && grp_ready_i) begin
                grp_valid_o <= 1'b0;
            end
            if (line_start_i) begin
                busy    <= 1'b1;
                phase   <= 2'd0;
                grp_cnt <= '0;
            end else if (step) begin
                if (last_phase) begin
                    phase       <= 2'd0;
                    grp_valid_o <= 1'b1;
                    grp_cnt     <= grp_cnt + 1'b1;
                    busy        <= grp_cnt != GRP_LAST;
                end else begin
                    phase <= phase + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (timing_i.last_frame_pixel) begin
            line_addr <= cfg_i.disp_addr;
        end else if (line_start_i) begin
            line_addr <= line_addr + cfg_i.line_len;
        end
        if (line_start_i) begin
            rd_addr <= line_addr;
        end else if (vram_sel_o) begin
            rd_addr <= rd_addr + 1'b1;
        end
        if (step && phase == 2'd1) begin
            word_q <= rd_word;
        end
        if (step && last_phase) begin
            grp_o <= (cfg_i.bpp == BPP_4) ? nib_grp : attr_grp;
        end
    end

endmodule

/* vgen_sync_timing.sv */
// video sync timing
`timescale 1ns/1ps
`include "vgen_params.svh"

module vgen_sync_timing (
    input  logic                clk,
    input  logic                reset_i,
    output vgen_pkg::timing_t   timing_o,
    output logic                line_start_o,   // fetch trigger on visible lines
    output logic                scan_active_o,  // visible area one cycle ahead
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                de_o
);

    localparam int CW = `VGEN_CNT_W;

    // last count of each phase
    localparam logic [CW-1:0] H_FRONT_LAST = CW'(`VGEN_H_FRONT - 1);
    localparam logic [CW-1:0] H_SYNC_LAST  = CW'(`VGEN_H_FRONT + `VGEN_H_SYNC - 1);
    localparam logic [CW-1:0] H_BACK_LAST  = CW'(`VGEN_H_FRONT + `VGEN_H_SYNC + `VGEN_H_BACK - 1);
    localparam logic [CW-1:0] H_TOTAL_LAST = H_BACK_LAST + CW'(`VGEN_H_VISIBLE);
    localparam logic [CW-1:0] H_FETCH      = H_BACK_LAST + 1'b1 - CW'(`VGEN_FETCH_LEAD);
    localparam logic [CW-1:0] V_VIS_LAST   = CW'(`VGEN_V_VISIBLE - 1);
    localparam logic [CW-1:0] V_FRONT_LAST = V_VIS_LAST + CW'(`VGEN_V_FRONT);
    localparam logic [CW-1:0] V_SYNC_LAST  = V_FRONT_LAST + CW'(`VGEN_V_SYNC);
    localparam logic [CW-1:0] V_TOTAL_LAST = V_SYNC_LAST + CW'(`VGEN_V_BACK);

    typedef enum logic [1:0] {
        ST_FRONT   = 2'b00,
        ST_SYNC    = 2'b01,
        ST_BACK    = 2'b10,
        ST_VISIBLE = 2'b11
    } axis_state_t;

    axis_state_t    h_state, h_state_next;
    axis_state_t    v_state, v_state_next;
    logic [CW-1:0]  h_count, v_count;
    logic [CW-1:0]  h_end, v_end;       // count at which the state advances
    logic           line_end;
    logic           frame_end;

    always_comb begin
        case (h_state)
            ST_FRONT: h_end = H_FRONT_LAST;
            ST_SYNC:  h_end = H_SYNC_LAST;
            ST_BACK:  h_end = H_BACK_LAST;
            default:  h_end = H_TOTAL_LAST;
        endcase
        case (v_state)
            ST_VISIBLE: v_end = V_VIS_LAST;     // visible lines are at the top
            ST_FRONT:   v_end = V_FRONT_LAST;
            ST_SYNC:    v_end = V_SYNC_LAST;
            default:    v_end = V_TOTAL_LAST;
        endcase
    end

    assign line_end     = h_count == H_TOTAL_LAST;
    assign frame_end    = line_end && v_state == ST_BACK && v_count == V_TOTAL_LAST;
    assign h_state_next = (h_count == h_end) ? axis_state_t'(h_state + 2'd1) : h_state;
    assign v_state_next = (line_end && v_count == v_end) ? axis_state_t'(v_state + 2'd1) : v_state;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= ST_FRONT;
            v_state <= ST_FRONT;
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= line_end ? '0 : h_count + 1'b1;
            if (line_end) begin
                v_count <= frame_end ? '0 : v_count + 1'b1;
            end
        end
    end

    assign timing_o.v_count          = v_count;
    assign timing_o.h_visible        = h_state == ST_VISIBLE;
    assign timing_o.v_visible        = v_state == ST_VISIBLE;
    assign timing_o.last_frame_pixel = frame_end;

    assign de_o          = timing_o.h_visible && timing_o.v_visible;
    assign scan_active_o = h_state_next == ST_VISIBLE && v_state_next == ST_VISIBLE;
    assign line_start_o  = v_state == ST_VISIBLE && h_count == H_FETCH;
    assign hsync_o       = (h_state == ST_SYNC) ? `VGEN_SYNC_POL : ~`VGEN_SYNC_POL;
    assign vsync_o       = (v_state == ST_SYNC) ? `VGEN_SYNC_POL : ~`VGEN_SYNC_POL;

endmodule

/* vgen_reg_decode.sv */
// APB configuration registers
`timescale 1ns/1ps
`include "vgen_params.svh"

module vgen_reg_decode (
    input  logic                clk,
    input  logic                reset_i,
    // APB slave
    input  logic [2:0]          paddr_i,        // word offset
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  logic [15:0]         pwdata_i,
    output logic [15:0]         prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    // status and configuration
    input  vgen_pkg::timing_t   timing_i,
    output vgen_pkg::pa_cfg_t   cfg_o,
    output logic [7:0]          border_o
);

    import vgen_pkg::*;

    logic access;
    logic bad_addr;
    logic wr_en;

    assign access   = psel_i && penable_i;
    assign bad_addr = paddr_i > `VGEN_REG_SCANLINE;

    // no wait states
    assign pready_o  = access;
    assign pslverr_o = access && (bad_addr || (pwrite_i && paddr_i == `VGEN_REG_SCANLINE));
    assign wr_en     = access && pwrite_i && !pslverr_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_o        <= `VGEN_RST_BORDER;
            cfg_o.colorbase <= 8'h00;
            cfg_o.blank     <= 1'b0;            // plane shown after reset
            cfg_o.bpp       <= BPP_1_ATTR;
            cfg_o.disp_addr <= '0;
            cfg_o.line_len  <= `VGEN_RST_LINE_LEN;
        end else if (wr_en) begin
            case (paddr_i)
                `VGEN_REG_VID_CTRL: begin
                    border_o <= pwdata_i[15:8];
                end
                `VGEN_REG_GFX_CTRL: begin
                    cfg_o.colorbase <= pwdata_i[15:8];
                    cfg_o.blank     <= pwdata_i[7];
                    cfg_o.bpp       <= bpp_t'(pwdata_i[4]);
                end
                `VGEN_REG_DISP_ADDR: begin
                    cfg_o.disp_addr <= pwdata_i;
                end
                `VGEN_REG_LINE_LEN: begin
                    cfg_o.line_len <= pwdata_i;
                end
                default: begin
                end
            endcase
        end
    end

    // read data valid in the access phase
    always_comb begin
        case (paddr_i)
            `VGEN_REG_VID_CTRL:  prdata_o = {border_o, 8'h00};
            `VGEN_REG_GFX_CTRL:  prdata_o = {cfg_o.colorbase, cfg_o.blank, 2'b00, cfg_o.bpp, 4'h0};
            `VGEN_REG_DISP_ADDR: prdata_o = cfg_o.disp_addr;
            `VGEN_REG_LINE_LEN:  prdata_o = cfg_o.line_len;
            `VGEN_REG_SCANLINE:  prdata_o = {!timing_i.v_visible, !timing_i.h_visible, 3'b000,
                                             timing_i.v_count};
            default:             prdata_o = 16'h0000;
        endcase
    end

endmodule

/* vgen_pkg.sv */
// video generator types
`include "vgen_params.svh"

package vgen_pkg;

    typedef enum logic {
        BPP_1_ATTR = 1'b0,                      // 1 bit per pixel with fg/bg attribute
        BPP_4      = 1'b1                       // 4 bits per pixel
    } bpp_t;

    // 1-bpp word, attribute in the high byte
    typedef struct packed {
        logic [3:0]     fg;                     // colour for set bits
        logic [3:0]     bg;                     // colour for clear bits
        logic [7:0]     pix;                    // bit 7 is the leftmost pixel
    } attr_word_t;

    typedef struct packed {
        logic [3:0][3:0] pix;                   // nibble 3 is the leftmost pixel
    } nib_word_t;

    // one vram word, decoded per bitmap depth
    typedef union packed {
        attr_word_t     attr_view;
        nib_word_t      nib_view;
    } vram_word_u;

    typedef struct packed {
        logic [7:0]                 colorbase;  // upper colour bits for plane pixels
        logic                       blank;      // plane hidden, border shown
        bpp_t                       bpp;
        logic [`VGEN_ADDR_W-1:0]    disp_addr;  // first word of the frame
        logic [`VGEN_ADDR_W-1:0]    line_len;   // words between line starts
    } pa_cfg_t;

    typedef struct packed {
        logic [`VGEN_CNT_W-1:0]     v_count;
        logic                       h_visible;
        logic                       v_visible;
        logic                       last_frame_pixel;
    } timing_t;

    // eight colour indices, first pixel in the top byte
    typedef logic [7:0][7:0] pixel_group_t;

endpackage

/* vgen_params.svh */
// video generator parameters
`ifndef VGEN_PARAMS_SVH
`define VGEN_PARAMS_SVH

// horizontal phases in pixels, offscreen columns come first
`define VGEN_H_FRONT        2
`define VGEN_H_SYNC         4
`define VGEN_H_BACK         2
`define VGEN_H_VISIBLE      32

// vertical phases in lines, visible lines come first
`define VGEN_V_VISIBLE      4
`define VGEN_V_FRONT        1
`define VGEN_V_SYNC         1
`define VGEN_V_BACK         1

`define VGEN_SYNC_POL       1'b1    // active level of hsync and vsync
`define VGEN_CNT_W          11      // h and v counter width
`define VGEN_ADDR_W         16      // vram word address width
`define VGEN_FETCH_LEAD     6       // pixels before visible area to start line fetch

`define VGEN_REG_VID_CTRL   3'd0
`define VGEN_REG_GFX_CTRL   3'd1
`define VGEN_REG_DISP_ADDR  3'd2
`define VGEN_REG_LINE_LEN   3'd3
`define VGEN_REG_SCANLINE   3'd4

`define VGEN_RST_BORDER     8'h08   // dark grey
`define VGEN_RST_LINE_LEN   16'd4

`endif
